// ==== build.f ====
src/mips_pkg.sv
src/pipe_ifs.sv
src/inst_intake.sv
src/id_decoder.sv
src/gpr_file.sv
src/alu_exec.sv
src/result_sender.sv
src/mips_exec_slice.sv
verif/tb_ref_model.sv
verif/tb_mips_exec_slice.sv

// ==== src/alu_exec.sv ====
module alu_exec (
	input  logic        clk,
	input  logic        reset_i,
	ex_bus_if.alu       ex_i,
	res_bus_if.alu      res_o,
	output logic        wr_en_o,
	output logic [4:0]  wr_addr_o,
	output logic [31:0] wr_data_o,
	output logic        fwd_wren_o,
	output logic [4:0]  fwd_waddr_o,
	output logic [31:0] fwd_data_o
);

	logic [31:0] result;
	logic [4:0]  shamt;
	logic        capture;

	assign shamt = ex_i.opr1[4:0];

	always_comb begin
		case (ex_i.aluop)
			mips_pkg::ALU_ADD:  result = ex_i.opr1 + ex_i.opr2;
			mips_pkg::ALU_SUB:  result = ex_i.opr1 - ex_i.opr2;
			mips_pkg::ALU_SLT:  result = {31'd0, $signed(ex_i.opr1) < $signed(ex_i.opr2)};
			mips_pkg::ALU_SLTU: result = {31'd0, ex_i.opr1 < ex_i.opr2};
			mips_pkg::ALU_AND:  result = ex_i.opr1 & ex_i.opr2;
			mips_pkg::ALU_OR:   result = ex_i.opr1 | ex_i.opr2;
			mips_pkg::ALU_XOR:  result = ex_i.opr1 ^ ex_i.opr2;
			mips_pkg::ALU_NOR:  result = ~(ex_i.opr1 | ex_i.opr2);
			mips_pkg::ALU_SLL:  result = ex_i.opr2 << shamt;
			mips_pkg::ALU_SRL:  result = ex_i.opr2 >> shamt;
			mips_pkg::ALU_SRA:  result = $unsigned($signed(ex_i.opr2) >>> shamt);
			mips_pkg::ALU_LUI:  result = {ex_i.opr2[15:0], 16'd0};
			default:            result = '0;
		endcase
	end

	// execute register is free or drains to the sender
	assign capture   = ex_i.valid && !res_o.hold;
	assign ex_i.hold = res_o.hold;

	// regfile write happens as the result enters the execute register
	assign wr_en_o   = capture && ex_i.wren && (ex_i.waddr != 5'd0);
	assign wr_addr_o = ex_i.waddr;
	assign wr_data_o = result;

	assign fwd_wren_o  = ex_i.valid && ex_i.wren;
	assign fwd_waddr_o = ex_i.waddr;
	assign fwd_data_o  = result;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			res_o.valid <= 1'b0;
		end else if (!res_o.hold) begin
			res_o.valid <= ex_i.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			res_o.pc    <= ex_i.pc;
			res_o.waddr <= ex_i.waddr;
			res_o.wren  <= ex_i.wren;
			res_o.wdata <= result;
		end
	end

endmodule

// ==== src/gpr_file.sv ====
module gpr_file (
	input  logic        clk,
	input  logic        reset_i,
	input  logic [4:0]  rs_addr_i,
	input  logic [4:0]  rt_addr_i,
	output logic [31:0] rs_data_o,
	output logic [31:0] rt_data_o,
	input  logic        wr_en_i,
	input  logic [4:0]  wr_addr_i,
	input  logic [31:0] wr_data_i
);

	// register 0 has no storage
	logic [31:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int k = 1; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != 5'd0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// same-cycle write is visible on the read ports
	always_comb begin
		if (rs_addr_i == 5'd0) begin
			rs_data_o = '0;
		end else if (wr_en_i && wr_addr_i == rs_addr_i) begin
			rs_data_o = wr_data_i;
		end else begin
			rs_data_o = regs[rs_addr_i];
		end
	end

	always_comb begin
		if (rt_addr_i == 5'd0) begin
			rt_data_o = '0;
		end else if (wr_en_i && wr_addr_i == rt_addr_i) begin
			rt_data_o = wr_data_i;
		end else begin
			rt_data_o = regs[rt_addr_i];
		end
	end

endmodule

// ==== src/id_decoder.sv ====
module id_decoder (
	input  logic        clk,
	input  logic        reset_i,

	input  logic        head_valid_i,
	input  logic [31:0] head_pc_i,
	input  logic [31:0] head_inst_i,
	output logic        pop_o,

	output logic [4:0]  rs_addr_o,
	output logic [4:0]  rt_addr_o,
	input  logic [31:0] rs_data_i,
	input  logic [31:0] rt_data_i,

	input  logic        fwd_wren_i,
	input  logic [4:0]  fwd_waddr_i,
	input  logic [31:0] fwd_data_i,

	ex_bus_if.dec       ex_o
);

	mips_pkg::mips_inst_u inst;
	mips_pkg::alu_op_e    aluop;
	logic                 legal;
	logic                 shift_op;
	logic                 i_type;
	logic [4:0]           waddr;
	logic                 wren;
	logic [31:0]          rs_val;
	logic [31:0]          rt_val;
	logic [31:0]          opr1;
	logic [31:0]          opr2;
	logic                 load_en;

	assign inst = head_inst_i;

	assign rs_addr_o = inst.r.rs;
	assign rt_addr_o = inst.r.rt;

	always_comb begin
		legal    = 1'b0;
		shift_op = 1'b0;
		aluop    = mips_pkg::ALU_ADD;
		case (inst.r.opcode)
			mips_pkg::OP_SPECIAL: begin
				legal = 1'b1;
				case (inst.r.funct)
					mips_pkg::FN_ADDU: aluop = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: aluop = mips_pkg::ALU_SUB;
					mips_pkg::FN_SLT:  aluop = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: aluop = mips_pkg::ALU_SLTU;
					mips_pkg::FN_AND:  aluop = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   aluop = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  aluop = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR:  aluop = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLL: begin
						aluop    = mips_pkg::ALU_SLL;
						shift_op = 1'b1;
					end
					mips_pkg::FN_SRL: begin
						aluop    = mips_pkg::ALU_SRL;
						shift_op = 1'b1;
					end
					mips_pkg::FN_SRA: begin
						aluop    = mips_pkg::ALU_SRA;
						shift_op = 1'b1;
					end
					default: legal = 1'b0;
				endcase
				// shifts need rs == 0, the rest need shamt == 0
				if (shift_op) begin
					legal = legal && (inst.r.rs == 5'd0);
				end else begin
					legal = legal && (inst.r.shamt == 5'd0);
				end
			end
			mips_pkg::OP_ADDIU: begin
				legal = 1'b1;
				aluop = mips_pkg::ALU_ADD;
			end
			mips_pkg::OP_LUI: begin
				legal = (inst.i.rs == 5'd0);
				aluop = mips_pkg::ALU_LUI;
			end
			default: legal = 1'b0;
		endcase
	end

	assign i_type = (inst.r.opcode != mips_pkg::OP_SPECIAL);
	assign waddr  = i_type ? inst.i.rt : inst.r.rd;
	assign wren   = legal && (waddr != 5'd0);

	// result of the instruction one stage ahead
	assign rs_val = (fwd_wren_i && fwd_waddr_i != 5'd0 && fwd_waddr_i == inst.r.rs) ?
			fwd_data_i : rs_data_i;
	assign rt_val = (fwd_wren_i && fwd_waddr_i != 5'd0 && fwd_waddr_i == inst.r.rt) ?
			fwd_data_i : rt_data_i;

	assign opr1 = shift_op ? {27'd0, inst.r.shamt} : rs_val;

	always_comb begin
		if (inst.r.opcode == mips_pkg::OP_ADDIU) begin
			opr2 = {{16{inst.i.imm[15]}}, inst.i.imm};
		end else if (inst.r.opcode == mips_pkg::OP_LUI) begin
			opr2 = {16'd0, inst.i.imm};
		end else begin
			opr2 = rt_val;
		end
	end

	// stage register is empty or moves on this cycle
	assign load_en = !ex_o.valid || !ex_o.hold;
	assign pop_o   = head_valid_i && load_en;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex_o.valid <= 1'b0;
		end else if (load_en) begin
			ex_o.valid <= head_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (pop_o) begin
			ex_o.pc    <= head_pc_i;
			ex_o.aluop <= aluop;
			ex_o.opr1  <= opr1;
			ex_o.opr2  <= opr2;
			ex_o.waddr <= waddr;
			ex_o.wren  <= wren;
		end
	end

endmodule

// ==== src/inst_intake.sv ====
module inst_intake #(
	parameter int INTAKE_DEPTH = 4
) (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        inst_valid_i,
	input  logic [31:0] inst_pc_i,
	input  logic [31:0] inst_word_i,
	input  logic        pop_i,
	output logic        head_valid_o,
	output logic [31:0] head_pc_o,
	output logic [31:0] head_inst_o,
	output logic        inst_credit_o
);

	localparam int PTR_W = (INTAKE_DEPTH > 1) ? $clog2(INTAKE_DEPTH) : 1;
	localparam int CNT_W = $clog2(INTAKE_DEPTH + 1);

	logic [31:0]      pc_mem   [INTAKE_DEPTH];
	logic [31:0]      word_mem [INTAKE_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             credit_q;

	// wrap at the last entry, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(INTAKE_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (inst_valid_i) begin
			pc_mem[wr_ptr]   <= inst_pc_i;
			word_mem[wr_ptr] <= inst_word_i;
		end
	end

	// sender obeys its credits, so no full check here
	always_ff @(posedge clk) begin
		if (reset_i) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			count    <= '0;
			credit_q <= 1'b0;
		end else begin
			if (inst_valid_i) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop_i) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count    <= count + CNT_W'(inst_valid_i) - CNT_W'(pop_i);
			credit_q <= pop_i;
		end
	end

	assign head_valid_o  = (count != '0);
	assign head_pc_o     = pc_mem[rd_ptr];
	assign head_inst_o   = word_mem[rd_ptr];
	assign inst_credit_o = credit_q;

endmodule

// ==== src/mips_exec_slice.sv ====
module mips_exec_slice #(
	parameter int INTAKE_DEPTH = 4,
	parameter int OUT_CREDITS  = 2
) (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        inst_valid_i,
	input  logic [31:0] inst_pc_i,
	input  logic [31:0] inst_word_i,
	output logic        inst_credit_o,
	output logic        res_valid_o,
	output logic [31:0] res_pc_o,
	output logic [4:0]  res_waddr_o,
	output logic        res_wren_o,
	output logic [31:0] res_wdata_o,
	input  logic        res_credit_i
);

	logic        head_valid;
	logic [31:0] head_pc;
	logic [31:0] head_inst;
	logic        pop;

	logic [4:0]  rs_addr;
	logic [4:0]  rt_addr;
	logic [31:0] rs_data;
	logic [31:0] rt_data;

	logic        wr_en;
	logic [4:0]  wr_addr;
	logic [31:0] wr_data;

	logic        fwd_wren;
	logic [4:0]  fwd_waddr;
	logic [31:0] fwd_data;

	ex_bus_if  ex_bus ();
	res_bus_if res_bus ();

	inst_intake #(
		.INTAKE_DEPTH(INTAKE_DEPTH)
	) u_intake (
		.clk           (clk),
		.reset_i       (reset_i),
		.inst_valid_i  (inst_valid_i),
		.inst_pc_i     (inst_pc_i),
		.inst_word_i   (inst_word_i),
		.pop_i         (pop),
		.head_valid_o  (head_valid),
		.head_pc_o     (head_pc),
		.head_inst_o   (head_inst),
		.inst_credit_o (inst_credit_o)
	);

	id_decoder u_dec (
		.clk          (clk),
		.reset_i      (reset_i),
		.head_valid_i (head_valid),
		.head_pc_i    (head_pc),
		.head_inst_i  (head_inst),
		.pop_o        (pop),
		.rs_addr_o    (rs_addr),
		.rt_addr_o    (rt_addr),
		.rs_data_i    (rs_data),
		.rt_data_i    (rt_data),
		.fwd_wren_i   (fwd_wren),
		.fwd_waddr_i  (fwd_waddr),
		.fwd_data_i   (fwd_data),
		.ex_o         (ex_bus.dec)
	);

	gpr_file u_gpr (
		.clk       (clk),
		.reset_i   (reset_i),
		.rs_addr_i (rs_addr),
		.rt_addr_i (rt_addr),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data)
	);

	alu_exec u_alu (
		.clk         (clk),
		.reset_i     (reset_i),
		.ex_i        (ex_bus.alu),
		.res_o       (res_bus.alu),
		.wr_en_o     (wr_en),
		.wr_addr_o   (wr_addr),
		.wr_data_o   (wr_data),
		.fwd_wren_o  (fwd_wren),
		.fwd_waddr_o (fwd_waddr),
		.fwd_data_o  (fwd_data)
	);

	result_sender #(
		.OUT_CREDITS(OUT_CREDITS)
	) u_snd (
		.clk          (clk),
		.reset_i      (reset_i),
		.res_i        (res_bus.snd),
		.res_credit_i (res_credit_i),
		.res_valid_o  (res_valid_o),
		.res_pc_o     (res_pc_o),
		.res_waddr_o  (res_waddr_o),
		.res_wren_o   (res_wren_o),
		.res_wdata_o  (res_wdata_o)
	);

endmodule

// ==== src/mips_pkg.sv ====
package mips_pkg;

	// one instruction word, seen as R-type or I-type fields
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
	} mips_inst_u;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLT  = 4'd2,
		ALU_SLTU = 4'd3,
		ALU_AND  = 4'd4,
		ALU_OR   = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_NOR  = 4'd7,
		ALU_SLL  = 4'd8,
		ALU_SRL  = 4'd9,
		ALU_SRA  = 4'd10,
		ALU_LUI  = 4'd11
	} alu_op_e;

	// major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// funct field of SPECIAL
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

// ==== src/pipe_ifs.sv ====
// decode register to ALU stage
interface ex_bus_if;
	logic              valid;
	logic [31:0]       pc;
	mips_pkg::alu_op_e aluop;
	logic [31:0]       opr1;
	logic [31:0]       opr2;
	logic [4:0]        waddr;
	logic              wren;
	logic              hold;

	modport dec (
		output valid, pc, aluop, opr1, opr2, waddr, wren,
		input  hold
	);

	modport alu (
		input  valid, pc, aluop, opr1, opr2, waddr, wren,
		output hold
	);
endinterface

// execute register to result sender
interface res_bus_if;
	logic        valid;
	logic [31:0] pc;
	logic [4:0]  waddr;
	logic        wren;
	logic [31:0] wdata;
	logic        hold;

	modport alu (
		output valid, pc, waddr, wren, wdata,
		input  hold
	);

	modport snd (
		input  valid, pc, waddr, wren, wdata,
		output hold
	);
endinterface

// ==== src/result_sender.sv ====
module result_sender #(
	parameter int OUT_CREDITS = 2
) (
	input  logic        clk,
	input  logic        reset_i,
	res_bus_if.snd      res_i,
	input  logic        res_credit_i,
	output logic        res_valid_o,
	output logic [31:0] res_pc_o,
	output logic [4:0]  res_waddr_o,
	output logic        res_wren_o,
	output logic [31:0] res_wdata_o
);

	localparam int CNT_W = $clog2(OUT_CREDITS + 1);

	logic [CNT_W-1:0] credits;
	logic             have_credit;
	logic             send;

	assign have_credit = (credits != '0);
	assign send        = res_i.valid && have_credit;

	// stall goes back to the execute register
	assign res_i.hold = res_i.valid && !have_credit;

	// a return and a send in one cycle cancel out
	always_ff @(posedge clk) begin
		if (reset_i) begin
			credits <= CNT_W'(OUT_CREDITS);
		end else begin
			credits <= credits + CNT_W'(res_credit_i) - CNT_W'(send);
		end
	end

	assign res_valid_o = send;
	assign res_pc_o    = res_i.pc;
	assign res_waddr_o = res_i.waddr;
	assign res_wren_o  = res_i.valid && res_i.wren;
	assign res_wdata_o = res_i.wdata;

endmodule

// ==== verif/tb_mips_exec_slice.sv ====
module tb_mips_exec_slice;

	localparam int INTAKE_DEPTH = 4;
	localparam int OUT_CREDITS  = 2;
	localparam int N_LOADS      = 15;
	localparam int N_ROPS       = 48;
	localparam int TOTAL_INSTS  = 2 * N_LOADS + N_ROPS + 24 + 24 + 12 + 30 + 12;
	localparam int CYCLE_LIMIT  = 40 * TOTAL_INSTS + 200;

	logic        clk;
	logic        reset_i;
	logic        inst_valid_i;
	logic [31:0] inst_pc_i;
	logic [31:0] inst_word_i;
	logic        inst_credit_o;
	logic        res_valid_o;
	logic [31:0] res_pc_o;
	logic [4:0]  res_waddr_o;
	logic        res_wren_o;
	logic [31:0] res_wdata_o;
	logic        res_credit_i;

	int          seed = 32'h9c1a_d8ed;
	int          credit_seed = 32'h9c1a_d8ed;
	int          issued_cnt;
	int          pulse_cnt;
	int          received_cnt;
	int          returned_cnt;
	int          held_sends;
	int          cycle_cnt;
	int          icredits;
	int          pending;
	int          model_err;
	int          tb_err;
	int          err_mark;
	int          failed_tests;
	logic        withhold;
	logic [31:0] next_pc;
	logic [5:0]  fn_list [11] = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_SLT,
			mips_pkg::FN_SLTU, mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR,
			mips_pkg::FN_NOR, mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA};

	mips_exec_slice #(
		.INTAKE_DEPTH(INTAKE_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) dut0 (
		.clk           (clk),
		.reset_i       (reset_i),
		.inst_valid_i  (inst_valid_i),
		.inst_pc_i     (inst_pc_i),
		.inst_word_i   (inst_word_i),
		.inst_credit_o (inst_credit_o),
		.res_valid_o   (res_valid_o),
		.res_pc_o      (res_pc_o),
		.res_waddr_o   (res_waddr_o),
		.res_wren_o    (res_wren_o),
		.res_wdata_o   (res_wdata_o),
		.res_credit_i  (res_credit_i)
	);

	tb_ref_model ref_model0 (
		.clk          (clk),
		.reset_i      (reset_i),
		.inst_valid_i (inst_valid_i),
		.inst_pc_i    (inst_pc_i),
		.inst_word_i  (inst_word_i),
		.res_valid_i  (res_valid_o),
		.res_pc_i     (res_pc_o),
		.res_waddr_i  (res_waddr_o),
		.res_wren_i   (res_wren_o),
		.res_wdata_i  (res_wdata_o),
		.pending_o    (pending),
		.err_cnt_o    (model_err)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// credits the outside still holds toward the intake
	assign icredits = INTAKE_DEPTH - (issued_cnt - pulse_cnt);

	always @(posedge clk) begin
		if (reset_i) begin
			issued_cnt   <= 0;
			pulse_cnt    <= 0;
			received_cnt <= 0;
			held_sends   <= 0;
		end else begin
			issued_cnt   <= issued_cnt + int'(inst_valid_i);
			pulse_cnt    <= pulse_cnt + int'(inst_credit_o);
			received_cnt <= received_cnt + int'(res_valid_o);
			if (!withhold) begin
				held_sends <= 0;
			end else if (res_valid_o) begin
				held_sends <= held_sends + 1;
			end
		end
	end

	// output credits come back at random gaps
	always @(negedge clk) begin
		if (reset_i) begin
			res_credit_i = 1'b0;
			returned_cnt = 0;
		end else if (withhold || returned_cnt == received_cnt ||
				($random(credit_seed) & 3) == 0) begin
			res_credit_i = 1'b0;
		end else begin
			res_credit_i = 1'b1;
			returned_cnt = returned_cnt + 1;
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d results still missing",
					cycle_cnt, pending);
			$display("Simulation failed");
			$finish;
		end
	end

	intake_credit_check: assert property (@(posedge clk) disable iff (reset_i)
			(issued_cnt - pulse_cnt) <= INTAKE_DEPTH &&
			(!inst_credit_o || pulse_cnt < issued_cnt))
	else begin
		$display("intake credits out of range, %0d sent and %0d returned",
				$sampled(issued_cnt), $sampled(pulse_cnt));
		tb_err++;
	end

	stall_check: assert property (@(posedge clk) disable iff (reset_i)
			withhold && res_valid_o |-> held_sends < OUT_CREDITS)
	else begin
		$display("more results sent than output credits while credits were held back");
		tb_err++;
	end

	function automatic logic [31:0] rword(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		mips_pkg::mips_inst_u w;
		w.r.opcode = mips_pkg::OP_SPECIAL;
		w.r.rs     = rs;
		w.r.rt     = rt;
		w.r.rd     = rd;
		w.r.shamt  = shamt;
		w.r.funct  = fn;
		return w;
	endfunction

	function automatic logic [31:0] iword(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		mips_pkg::mips_inst_u w;
		w.i.opcode = op;
		w.i.rs     = rs;
		w.i.rt     = rt;
		w.i.imm    = imm;
		return w;
	endfunction

	// registers 0..15 only
	// shifts are the last three list entries
	function automatic logic [31:0] random_op(input logic r_only);
		int         pick;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		pick = ($random(seed) & 32'h7fff_ffff) % (r_only ? 11 : 13);
		rs = 5'($random(seed) & 15);
		rt = 5'($random(seed) & 15);
		rd = 5'($random(seed) & 15);
		if (pick == 11) begin
			return iword(mips_pkg::OP_ADDIU, rs, rt, 16'($random(seed)));
		end
		if (pick == 12) begin
			return iword(mips_pkg::OP_LUI, 5'd0, rt, 16'($random(seed)));
		end
		if (pick >= 8) begin
			return rword(fn_list[pick], 5'd0, rt, rd, 5'($random(seed)));
		end
		return rword(fn_list[pick], rs, rt, rd, 5'd0);
	endfunction

	task automatic issue(input logic [31:0] word);
		while (icredits == 0) begin
			@(negedge clk);
		end
		inst_valid_i = 1'b1;
		inst_pc_i    = next_pc;
		inst_word_i  = word;
		@(negedge clk);
		inst_valid_i = 1'b0;
		next_pc      = next_pc + 32'd4;
	endtask

	task automatic end_test(input int num, input string name);
		int errs;
		while (pending != 0 || returned_cnt != received_cnt) begin
			@(negedge clk);
		end
		@(negedge clk);
		pulse_total: assert (pulse_cnt == issued_cnt)
		else begin
			$display("Error: inst_credit_o pulses = %h, expected %h",
					pulse_cnt, issued_cnt);
			tb_err++;
		end
		errs = model_err + tb_err - err_mark;
		if (errs != 0) begin
			failed_tests++;
		end
		$display("test %0d %s: %0d errors", num, name, errs);
		err_mark = model_err + tb_err;
	endtask

	initial begin
		int gap;
		inst_valid_i = 1'b0;
		inst_pc_i    = '0;
		inst_word_i  = '0;
		res_credit_i = 1'b0;
		reset_i      = 1'b1;
		withhold     = 1'b0;
		next_pc      = 32'h0000_1000;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;

		// random register contents first
		for (int k = 1; k <= N_LOADS; k++) begin
			issue(iword(mips_pkg::OP_LUI, 5'd0, 5'(k), 16'($random(seed))));
			issue(iword(mips_pkg::OP_ADDIU, 5'(k), 5'(k), 16'($random(seed))));
		end
		for (int k = 0; k < N_ROPS; k++) begin
			issue(random_op(1'b1));
		end
		end_test(1, "r-type operations");

		for (int k = 0; k < 12; k++) begin
			issue(iword(mips_pkg::OP_ADDIU, 5'($random(seed) & 15), 5'(16 + (k & 7)),
					16'($random(seed)) | 16'h8000));
			issue(iword(mips_pkg::OP_LUI, 5'd0, 5'(24 + (k & 7)), 16'($random(seed))));
		end
		end_test(2, "immediates");

		// each one reads the result just ahead of it
		for (int k = 0; k < 8; k++) begin
			issue(iword(mips_pkg::OP_ADDIU, 5'd22, 5'd20, 16'(k * 3 + 1)));
			issue(rword(mips_pkg::FN_ADDU, 5'd20, 5'd21, 5'd21, 5'd0));
			issue(rword(mips_pkg::FN_SUBU, 5'd21, 5'd20, 5'd22, 5'd0));
		end
		end_test(3, "forwarding");

		withhold = 1'b1;
		for (int k = 0; k < 12; k++) begin
			while (withhold && icredits == 0) begin
				if (held_sends == OUT_CREDITS) begin
					withhold = 1'b0;
				end else begin
					@(negedge clk);
				end
			end
			issue(random_op(1'b0));
		end
		withhold = 1'b0;
		end_test(4, "output stall");

		for (int k = 0; k < 30; k++) begin
			gap = $random(seed) & 3;
			repeat (gap) @(negedge clk);
			issue(random_op(1'b0));
		end
		end_test(5, "intake credits");

		for (int k = 0; k < 3; k++) begin
			issue(iword(6'h23, 5'd1, 5'd2, 16'h0040));
			issue(rword(6'h18, 5'd3, 5'd4, 5'd5, 5'd0));
			issue(iword(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h1234));
			issue(rword(mips_pkg::FN_OR, 5'd0, 5'd0, 5'(7 + k), 5'd0));
		end
		end_test(6, "illegal and r0");

		$display("tests run 6, tests failed %0d, errors %0d",
				failed_tests, model_err + tb_err);
		if (failed_tests == 0 && model_err + tb_err == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== verif/tb_ref_model.sv ====
module tb_ref_model (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        inst_valid_i,
	input  logic [31:0] inst_pc_i,
	input  logic [31:0] inst_word_i,
	input  logic        res_valid_i,
	input  logic [31:0] res_pc_i,
	input  logic [4:0]  res_waddr_i,
	input  logic        res_wren_i,
	input  logic [31:0] res_wdata_i,
	output int          pending_o,
	output int          err_cnt_o
);

	localparam int QSIZE = 32;

	logic [31:0] shadow  [32];
	logic [31:0] q_pc    [QSIZE];
	logic [4:0]  q_waddr [QSIZE];
	logic        q_wren  [QSIZE];
	logic [31:0] q_wdata [QSIZE];
	int          wr_cnt;
	int          rd_cnt;
	logic [31:0] exp_pc;
	logic [4:0]  exp_waddr;
	logic        exp_wren;
	logic [31:0] exp_wdata;

	// legal flag in bit 32, value below
	function automatic logic [32:0] predict(input mips_pkg::mips_inst_u w);
		logic [31:0] a;
		logic [31:0] b;
		logic [63:0] wide;
		logic [31:0] val;
		logic        legal;
		a = shadow[w.r.rs];
		b = shadow[w.r.rt];
		wide = {{32{b[31]}}, b} >> w.r.shamt;
		val = '0;
		legal = 1'b1;
		case (w.r.opcode)
			mips_pkg::OP_SPECIAL: begin
				case (w.r.funct)
					mips_pkg::FN_ADDU: val = a + b;
					mips_pkg::FN_SUBU: val = a - b;
					// differing signs decide on the sign bit alone
					mips_pkg::FN_SLT:  val = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
					mips_pkg::FN_SLTU: val = {31'd0, a < b};
					mips_pkg::FN_AND:  val = a & b;
					mips_pkg::FN_OR:   val = a | b;
					mips_pkg::FN_XOR:  val = a ^ b;
					mips_pkg::FN_NOR:  val = ~(a | b);
					mips_pkg::FN_SLL:  val = b << w.r.shamt;
					mips_pkg::FN_SRL:  val = b >> w.r.shamt;
					mips_pkg::FN_SRA:  val = wide[31:0];
					default:           legal = 1'b0;
				endcase
				if (w.r.funct == mips_pkg::FN_SLL || w.r.funct == mips_pkg::FN_SRL ||
						w.r.funct == mips_pkg::FN_SRA) begin
					legal = legal && (w.r.rs == 5'd0);
				end else begin
					legal = legal && (w.r.shamt == 5'd0);
				end
			end
			mips_pkg::OP_ADDIU: val = a + {{16{w.i.imm[15]}}, w.i.imm};
			mips_pkg::OP_LUI: begin
				val = {w.i.imm, 16'd0};
				legal = (w.i.rs == 5'd0);
			end
			default: legal = 1'b0;
		endcase
		return {legal, val};
	endfunction

	always @(posedge clk) begin
		mips_pkg::mips_inst_u w;
		logic [32:0]          p;
		logic [4:0]           dest;
		logic                 wr;
		if (reset_i) begin
			for (int k = 0; k < 32; k++) begin
				shadow[k] = '0;
			end
			wr_cnt = 0;
			rd_cnt = 0;
		end else begin
			if (res_valid_i) begin
				rd_cnt = rd_cnt + 1;
			end
			if (inst_valid_i) begin
				w = inst_word_i;
				p = predict(w);
				dest = (w.r.opcode == mips_pkg::OP_SPECIAL) ? w.r.rd : w.i.rt;
				wr = p[32] && (dest != 5'd0);
				q_pc[wr_cnt % QSIZE]    = inst_pc_i;
				q_waddr[wr_cnt % QSIZE] = dest;
				q_wren[wr_cnt % QSIZE]  = wr;
				q_wdata[wr_cnt % QSIZE] = p[31:0];
				if (wr) begin
					shadow[dest] = p[31:0];
				end
				wr_cnt = wr_cnt + 1;
			end
		end
	end

	assign pending_o = wr_cnt - rd_cnt;
	assign exp_pc    = q_pc[rd_cnt % QSIZE];
	assign exp_waddr = q_waddr[rd_cnt % QSIZE];
	assign exp_wren  = q_wren[rd_cnt % QSIZE];
	assign exp_wdata = q_wdata[rd_cnt % QSIZE];

	order_check: assert property (@(posedge clk) disable iff (reset_i)
			res_valid_i |-> pending_o != 0)
	else begin
		$display("result sent while no instruction was outstanding");
		err_cnt_o++;
	end

	pc_check: assert property (@(posedge clk) disable iff (reset_i)
			res_valid_i |-> res_pc_i == exp_pc)
	else begin
		$display("Error: res_pc_o = %h, expected %h", $sampled(res_pc_i), $sampled(exp_pc));
		err_cnt_o++;
	end

	wren_check: assert property (@(posedge clk) disable iff (reset_i)
			res_valid_i |-> res_wren_i == exp_wren)
	else begin
		$display("Error: res_wren_o = %h, expected %h", $sampled(res_wren_i),
				$sampled(exp_wren));
		err_cnt_o++;
	end

	waddr_check: assert property (@(posedge clk) disable iff (reset_i)
			res_valid_i && exp_wren |-> res_waddr_i == exp_waddr)
	else begin
		$display("Error: res_waddr_o = %h, expected %h", $sampled(res_waddr_i),
				$sampled(exp_waddr));
		err_cnt_o++;
	end

	wdata_check: assert property (@(posedge clk) disable iff (reset_i)
			res_valid_i && exp_wren |-> res_wdata_i == exp_wdata)
	else begin
		$display("Error: res_wdata_o = %h, expected %h", $sampled(res_wdata_i),
				$sampled(exp_wdata));
		err_cnt_o++;
	end

endmodule
